/* src/video_settings.svh */
`ifndef VIDEO_SETTINGS_SVH
`define VIDEO_SETTINGS_SVH

// sprite inputs, sets the packed sprite bus widths
`define VIDEO_NUM_SPRITES 8

// dot clock is a quarter of clk_dot4x
`define VIDEO_DOT_CLKS 4

// scroll register is only picked up inside this cell window
`define VIDEO_FIRST_VIS_CYCLE 15
`define VIDEO_LAST_VIS_CYCLE 55

// palette index for blanked pixels
`define VIDEO_BLACK 4'h0

`endif

/* src/video_pkg.sv */
package video_pkg;

    // palette index
    typedef logic [3:0] color_t;

    // mode bits packed as {ecm, bmm, mcm}
    typedef enum logic [2:0] {
        MODE_STD_CHAR          = 3'b000,
        MODE_MC_CHAR           = 3'b001,
        MODE_STD_BITMAP        = 3'b010,
        MODE_MC_BITMAP         = 3'b011,
        MODE_ECM_CHAR          = 3'b100,
        MODE_INV_ECM_MC_CHAR   = 3'b101,
        MODE_INV_ECM_BITMAP    = 3'b110,
        MODE_INV_ECM_MC_BITMAP = 3'b111
    } gfx_mode_e;

    // ecm together with bmm or mcm has no defined output
    function automatic logic is_invalid_mode(gfx_mode_e mode);
        return mode inside {MODE_INV_ECM_MC_CHAR, MODE_INV_ECM_BITMAP,
                            MODE_INV_ECM_MC_BITMAP};
    endfunction

endpackage

/* src/dot_timing.sv */
`include "video_settings.svh"

module dot_timing (
    input  logic       clk_dot4x,
    input  logic       rst,
    output logic       dot_rise0_o,
    output logic       dot_rise1_o,
    output logic       fetch_stb_o,
    output logic       load_stb_o,
    output logic       scroll_stb_o,
    output logic [2:0] xpos_mod8_o,
    output logic [6:0] cycle_num_o
);

    localparam logic [1:0] LAST_PHASE = 2'(`VIDEO_DOT_CLKS - 1);
    localparam logic [6:0] LAST_CELL = 7'd62;

    logic [1:0] phase_q;
    logic [1:0] phase_nxt;
    logic [2:0] dot_q;
    logic [2:0] dot_nxt;
    logic [6:0] cell_q;
    logic [6:0] cell_nxt;

    always_comb begin
        phase_nxt = (phase_q == LAST_PHASE) ? 2'd0 : phase_q + 2'd1;
        dot_nxt = dot_q;
        cell_nxt = cell_q;
        if (phase_q == LAST_PHASE) begin
            dot_nxt = dot_q + 3'd1;
            if (dot_q == 3'd7)
                cell_nxt = (cell_q == LAST_CELL) ? 7'd0 : cell_q + 7'd1;
        end
    end

    // strobes are decoded from the next count so they line up with the counters
    always_ff @(posedge clk_dot4x) begin
        if (rst) begin
            phase_q      <= 2'd0;
            dot_q        <= 3'd0;
            cell_q       <= 7'd0;
            dot_rise0_o  <= 1'b0;
            dot_rise1_o  <= 1'b0;
            fetch_stb_o  <= 1'b0;
            load_stb_o   <= 1'b0;
            scroll_stb_o <= 1'b0;
        end else begin
            phase_q      <= phase_nxt;
            dot_q        <= dot_nxt;
            cell_q       <= cell_nxt;
            dot_rise0_o  <= (phase_nxt == 2'd0);
            dot_rise1_o  <= (phase_nxt == 2'd1);
            fetch_stb_o  <= (phase_nxt == 2'd2) && (dot_nxt == 3'd1);
            load_stb_o   <= (phase_nxt == 2'd2) && (dot_nxt == 3'd6);
            scroll_stb_o <= (phase_nxt == LAST_PHASE) && (dot_nxt == 3'd7);
        end
    end

    // shifter position leads the dot count by one,
    // so scroll 0 loads on dot 7 right after load_stb
    assign xpos_mod8_o = dot_q + 3'd1;
    assign cycle_num_o = cell_q;

endmodule

/* src/gfx_delay_line.sv */
module gfx_delay_line #(
    parameter type payload_t = logic [7:0]
) (
    input  logic     clk_dot4x,
    input  logic     rst,
    input  logic     fetch_stb_i,
    input  logic     load_stb_i,
    input  payload_t data_i,
    output payload_t data_o
);

    payload_t stage0_q;
    payload_t stage1_q;

    // a cell's fetch lands in stage0, moves on at the next fetch
    always_ff @(posedge clk_dot4x) begin
        if (rst) begin
            stage0_q <= '0;
            stage1_q <= '0;
            data_o   <= '0;
        end else begin
            if (fetch_stb_i) begin
                stage0_q <= data_i;
                stage1_q <= stage0_q;
            end
            // held for the shifter until the next load point
            if (load_stb_i)
                data_o <= stage1_q;
        end
    end

endmodule

/* src/pixel_sequencer.sv */
`include "video_settings.svh"

module pixel_sequencer (
    input  logic                 clk_dot4x,
    input  logic                 rst,
    input  logic                 dot_rise0_i,
    input  logic                 dot_rise1_i,
    input  logic                 scroll_stb_i,
    input  logic [2:0]           xpos_mod8_i,
    input  logic [6:0]           cycle_num_i,
    input  logic [2:0]           xscroll_i,
    input  video_pkg::gfx_mode_e mode_i,
    input  logic [7:0]           pixels_i,
    input  logic [11:0]          char_i,
    input  video_pkg::color_t    b0c_i,
    input  video_pkg::color_t    b1c_i,
    input  video_pkg::color_t    b2c_i,
    input  video_pkg::color_t    b3c_i,
    output logic                 stage1_o,
    output logic                 is_bg_o,
    output video_pkg::color_t    color_o
);

    logic [2:0]        xscroll_q;
    logic              load_pix;
    logic              mcm;
    logic              bmm;
    logic              ecm;
    logic              mc_shift;
    logic              shift_en_q;
    logic [7:0]        pix_sh_q;
    logic [11:0]       char_sh_q;
    logic              is_bg0_q;
    logic              stage0_q;
    video_pkg::color_t color_nxt;

    assign {ecm, bmm, mcm} = mode_i;

    // bit 11 of the char word is the multicolour flag of the cell
    assign mc_shift = mcm & (bmm | ecm | char_sh_q[11]);
    assign load_pix = (xpos_mod8_i == xscroll_q);

    always_ff @(posedge clk_dot4x) begin
        if (rst) begin
            xscroll_q <= 3'd0;
        end else if (scroll_stb_i && cycle_num_i >= 7'(`VIDEO_FIRST_VIS_CYCLE) &&
                     cycle_num_i <= 7'(`VIDEO_LAST_VIS_CYCLE)) begin
            xscroll_q <= xscroll_i;
        end
    end

    // multicolour shifts every other dot, starting two dots after the load
    always_ff @(posedge clk_dot4x) begin
        if (rst) begin
            shift_en_q <= 1'b0;
        end else if (dot_rise0_i) begin
            if (load_pix)
                shift_en_q <= 1'b1;
            else if (mc_shift)
                shift_en_q <= ~shift_en_q;
        end
    end

    always_ff @(posedge clk_dot4x) begin
        if (dot_rise1_i && load_pix)
            char_sh_q <= char_i;
    end

    always_ff @(posedge clk_dot4x) begin
        if (rst) begin
            pix_sh_q <= 8'd0;
            is_bg0_q <= 1'b1;
        end else if (dot_rise1_i) begin
            if (load_pix) begin
                pix_sh_q <= pixels_i;
                is_bg0_q <= ~pixels_i[7];
            end else if (shift_en_q) begin
                if (mc_shift) begin
                    pix_sh_q <= {pix_sh_q[5:0], 2'b00};
                    is_bg0_q <= ~pix_sh_q[5];
                end else begin
                    pix_sh_q <= {pix_sh_q[6:0], 1'b0};
                    is_bg0_q <= ~pix_sh_q[6];
                end
            end
        end
    end

    always_comb begin
        color_nxt = `VIDEO_BLACK;
        if (!video_pkg::is_invalid_mode(mode_i)) begin
            case (mode_i)
                video_pkg::MODE_STD_CHAR:
                    color_nxt = pix_sh_q[7] ? char_sh_q[11:8] : b0c_i;
                video_pkg::MODE_MC_CHAR:
                    if (char_sh_q[11]) begin
                        case (pix_sh_q[7:6])
                            2'b00:   color_nxt = b0c_i;
                            2'b01:   color_nxt = b1c_i;
                            2'b10:   color_nxt = b2c_i;
                            default: color_nxt = {1'b0, char_sh_q[10:8]};
                        endcase
                    end else begin
                        // hires fallback for cells without the mc flag
                        color_nxt = pix_sh_q[7] ? char_sh_q[11:8] : b0c_i;
                    end
                video_pkg::MODE_STD_BITMAP:
                    color_nxt = pix_sh_q[7] ? char_sh_q[7:4] : char_sh_q[3:0];
                video_pkg::MODE_MC_BITMAP:
                    case (pix_sh_q[7:6])
                        2'b00:   color_nxt = b0c_i;
                        2'b01:   color_nxt = char_sh_q[7:4];
                        2'b10:   color_nxt = char_sh_q[3:0];
                        default: color_nxt = char_sh_q[11:8];
                    endcase
                video_pkg::MODE_ECM_CHAR:
                    // top two screen code bits pick the background
                    case ({pix_sh_q[7], char_sh_q[7:6]})
                        3'b000:  color_nxt = b0c_i;
                        3'b001:  color_nxt = b1c_i;
                        3'b010:  color_nxt = b2c_i;
                        3'b011:  color_nxt = b3c_i;
                        default: color_nxt = char_sh_q[11:8];
                    endcase
                default:
                    color_nxt = `VIDEO_BLACK;
            endcase
        end
    end

    always_ff @(posedge clk_dot4x) begin
        if (rst) begin
            stage0_q <= 1'b0;
            stage1_o <= 1'b0;
        end else begin
            stage0_q <= dot_rise1_i;
            stage1_o <= stage0_q;
        end
    end

    always_ff @(posedge clk_dot4x) begin
        if (stage0_q) begin
            color_o <= color_nxt;
            is_bg_o <= is_bg0_q;
        end
    end

endmodule

/* src/pixel_compositor.sv */
`include "video_settings.svh"

module pixel_compositor (
    input  logic                               clk_dot4x,
    input  logic                               rst,
    input  logic                               dot_rise1_i,
    input  logic                               stage1_i,
    input  video_pkg::gfx_mode_e               mode_i,
    input  logic                               is_bg_i,
    input  video_pkg::color_t                  color_i,
    input  logic [2*`VIDEO_NUM_SPRITES-1:0]    sprite_pix_i,
    input  logic [`VIDEO_NUM_SPRITES-1:0]      sprite_pri_i,
    input  logic [`VIDEO_NUM_SPRITES-1:0]      sprite_mmc_i,
    input  logic [4*`VIDEO_NUM_SPRITES-1:0]    sprite_col_i,
    input  video_pkg::color_t                  sprite_mc0_i,
    input  video_pkg::color_t                  sprite_mc1_i,
    input  logic                               border_i,
    input  video_pkg::color_t                  ec_i,
    output video_pkg::color_t                  pixel_color_o,
    output logic                               pixel_stb_o
);

    localparam int NSPR = `VIDEO_NUM_SPRITES;

    logic [1:0]        spr_pix [NSPR];
    video_pkg::color_t spr_col [NSPR];
    video_pkg::color_t base_color;
    video_pkg::color_t ovl_color;
    video_pkg::color_t color_s2_q;
    video_pkg::color_t color_s2a_q;
    logic              border_s2_q;
    logic              border_s2a_q;
    logic              adv_q;

    // sprite 0 sits in the top slice of each packed bus
    for (genvar n = 0; n < NSPR; n++) begin : g_unpack
        assign spr_pix[n] = sprite_pix_i[2*(NSPR-1-n) +: 2];
        assign spr_col[n] = sprite_col_i[4*(NSPR-1-n) +: 4];
    end

    always_comb begin
        base_color = video_pkg::is_invalid_mode(mode_i) ? `VIDEO_BLACK : color_i;
        ovl_color = base_color;
        // walk down so sprite 0 is applied last and wins
        for (int n = NSPR - 1; n >= 0; n--) begin
            if (!sprite_pri_i[n] || is_bg_i) begin
                if (sprite_mmc_i[n]) begin
                    case (spr_pix[n])
                        2'b01:   ovl_color = sprite_mc0_i;
                        2'b10:   ovl_color = spr_col[n];
                        2'b11:   ovl_color = sprite_mc1_i;
                        default: ovl_color = ovl_color;
                    endcase
                end else if (spr_pix[n][1]) begin
                    ovl_color = spr_col[n];
                end
            end
            // a behind-fg sprite above wins back the graphics over a lower one
            if (sprite_pri_i[n] && !is_bg_i && spr_pix[n][1])
                ovl_color = base_color;
        end
    end

    always_ff @(posedge clk_dot4x) begin
        if (stage1_i) begin
            color_s2_q  <= ovl_color;
            border_s2_q <= border_i;
        end
    end

    // one extra dot so the output lines up with border edges
    always_ff @(posedge clk_dot4x) begin
        if (dot_rise1_i) begin
            color_s2a_q  <= color_s2_q;
            border_s2a_q <= border_s2_q;
        end
    end

    always_ff @(posedge clk_dot4x) begin
        if (rst) begin
            adv_q         <= 1'b0;
            pixel_stb_o   <= 1'b0;
            pixel_color_o <= `VIDEO_BLACK;
        end else begin
            adv_q       <= dot_rise1_i;
            pixel_stb_o <= adv_q;
            if (adv_q)
                pixel_color_o <= border_s2a_q ? ec_i : color_s2a_q;
        end
    end

endmodule

/* src/video_pixel_top.sv */
`include "video_settings.svh"

module video_pixel_top (
    input  logic                               clk_dot4x,
    input  logic                               rst,
    input  logic [2:0]                         xscroll_i,
    input  video_pkg::gfx_mode_e               mode_i,
    input  logic [7:0]                         pixels_read_i,
    input  logic [11:0]                        char_read_i,
    input  video_pkg::color_t                  b0c_i,
    input  video_pkg::color_t                  b1c_i,
    input  video_pkg::color_t                  b2c_i,
    input  video_pkg::color_t                  b3c_i,
    input  video_pkg::color_t                  ec_i,
    input  logic                               border_i,
    input  logic [2*`VIDEO_NUM_SPRITES-1:0]    sprite_pix_i,
    input  logic [`VIDEO_NUM_SPRITES-1:0]      sprite_pri_i,
    input  logic [`VIDEO_NUM_SPRITES-1:0]      sprite_mmc_i,
    input  logic [4*`VIDEO_NUM_SPRITES-1:0]    sprite_col_i,
    input  video_pkg::color_t                  sprite_mc0_i,
    input  video_pkg::color_t                  sprite_mc1_i,
    output video_pkg::color_t                  pixel_color_o,
    output logic                               pixel_stb_o
);

    logic              dot_rise0;
    logic              dot_rise1;
    logic              fetch_stb;
    logic              load_stb;
    logic              scroll_stb;
    logic [2:0]        xpos_mod8;
    logic [6:0]        cycle_num;
    logic [7:0]        pixels_dly;
    logic [11:0]       char_dly;
    logic              stage1;
    logic              is_bg;
    video_pkg::color_t seq_color;

    dot_timing u_timing (
        .clk_dot4x    (clk_dot4x),
        .rst          (rst),
        .dot_rise0_o  (dot_rise0),
        .dot_rise1_o  (dot_rise1),
        .fetch_stb_o  (fetch_stb),
        .load_stb_o   (load_stb),
        .scroll_stb_o (scroll_stb),
        .xpos_mod8_o  (xpos_mod8),
        .cycle_num_o  (cycle_num)
    );

    // a cell's bus data shows up at the output from dot 0 two cells later
    gfx_delay_line #(.payload_t(logic [7:0])) u_pixels_dly (
        .clk_dot4x   (clk_dot4x),
        .rst         (rst),
        .fetch_stb_i (fetch_stb),
        .load_stb_i  (load_stb),
        .data_i      (pixels_read_i),
        .data_o      (pixels_dly)
    );

    gfx_delay_line #(.payload_t(logic [11:0])) u_char_dly (
        .clk_dot4x   (clk_dot4x),
        .rst         (rst),
        .fetch_stb_i (fetch_stb),
        .load_stb_i  (load_stb),
        .data_i      (char_read_i),
        .data_o      (char_dly)
    );

    pixel_sequencer u_seq (
        .clk_dot4x    (clk_dot4x),
        .rst          (rst),
        .dot_rise0_i  (dot_rise0),
        .dot_rise1_i  (dot_rise1),
        .scroll_stb_i (scroll_stb),
        .xpos_mod8_i  (xpos_mod8),
        .cycle_num_i  (cycle_num),
        .xscroll_i    (xscroll_i),
        .mode_i       (mode_i),
        .pixels_i     (pixels_dly),
        .char_i       (char_dly),
        .b0c_i        (b0c_i),
        .b1c_i        (b1c_i),
        .b2c_i        (b2c_i),
        .b3c_i        (b3c_i),
        .stage1_o     (stage1),
        .is_bg_o      (is_bg),
        .color_o      (seq_color)
    );

    pixel_compositor u_comp (
        .clk_dot4x     (clk_dot4x),
        .rst           (rst),
        .dot_rise1_i   (dot_rise1),
        .stage1_i      (stage1),
        .mode_i        (mode_i),
        .is_bg_i       (is_bg),
        .color_i       (seq_color),
        .sprite_pix_i  (sprite_pix_i),
        .sprite_pri_i  (sprite_pri_i),
        .sprite_mmc_i  (sprite_mmc_i),
        .sprite_col_i  (sprite_col_i),
        .sprite_mc0_i  (sprite_mc0_i),
        .sprite_mc1_i  (sprite_mc1_i),
        .border_i      (border_i),
        .ec_i          (ec_i),
        .pixel_color_o (pixel_color_o),
        .pixel_stb_o   (pixel_stb_o)
    );

endmodule

/* tests/video_pixel_chk.sv */
`include "video_settings.svh"

module video_pixel_chk (
    input logic       clk_dot4x,
    input logic       rst,
    input logic       dot_rise0_i,
    input logic       dot_rise1_i,
    input logic       fetch_stb_i,
    input logic       load_stb_i,
    input logic       scroll_stb_i,
    input logic       pixel_stb_i,
    input logic [3:0] pixel_color_i
);

    // failed assertions so far
    int err_count = 0;

    // one pixel per dot, dot is four clocks
    a_stb_spacing: assert property (@(posedge clk_dot4x) disable iff (rst)
        pixel_stb_i |=> !pixel_stb_i [*3] ##1 pixel_stb_i)
        else begin
            err_count++;
            $error("pixel_stb_o spacing is not 4 clocks");
        end

    a_reset_quiet: assert property (@(posedge clk_dot4x)
        rst |=> !(dot_rise0_i || dot_rise1_i || fetch_stb_i || load_stb_i ||
                  scroll_stb_i || pixel_stb_i))
        else begin
            err_count++;
            $error("strobe high during reset");
        end

    a_reset_black: assert property (@(posedge clk_dot4x)
        $fell(rst) |-> pixel_color_i == `VIDEO_BLACK)
        else begin
            err_count++;
            $error("output not black after reset");
        end

endmodule

bind video_pixel_top video_pixel_chk u_chk (
    .clk_dot4x     (clk_dot4x),
    .rst           (rst),
    .dot_rise0_i   (dot_rise0),
    .dot_rise1_i   (dot_rise1),
    .fetch_stb_i   (fetch_stb),
    .load_stb_i    (load_stb),
    .scroll_stb_i  (scroll_stb),
    .pixel_stb_i   (pixel_stb_o),
    .pixel_color_i (pixel_color_o)
);

/* tests/tb_video_pixel.sv */
`include "video_settings.svh"

module tb_video_pixel;

    logic                                clk_dot4x;
    logic                                rst;
    logic [2:0]                          xscroll_i;
    video_pkg::gfx_mode_e                mode_i;
    logic [7:0]                          pixels_read_i;
    logic [11:0]                         char_read_i;
    video_pkg::color_t                   b0c_i;
    video_pkg::color_t                   b1c_i;
    video_pkg::color_t                   b2c_i;
    video_pkg::color_t                   b3c_i;
    video_pkg::color_t                   ec_i;
    logic                                border_i;
    logic [2*`VIDEO_NUM_SPRITES-1:0]     sprite_pix_i;
    logic [`VIDEO_NUM_SPRITES-1:0]       sprite_pri_i;
    logic [`VIDEO_NUM_SPRITES-1:0]       sprite_mmc_i;
    logic [4*`VIDEO_NUM_SPRITES-1:0]     sprite_col_i;
    video_pkg::color_t                   sprite_mc0_i;
    video_pkg::color_t                   sprite_mc1_i;
    video_pkg::color_t                   pixel_color_o;
    logic                                pixel_stb_o;

    string             lines[$];
    video_pkg::color_t got_q[$];
    time               got_t[$];
    logic [31:0]       fld [0:16];
    int                errors;
    int                cell_idx;
    int                cycles;
    int                cycle_limit;

    video_pixel_top uut (
        .clk_dot4x     (clk_dot4x),
        .rst           (rst),
        .xscroll_i     (xscroll_i),
        .mode_i        (mode_i),
        .pixels_read_i (pixels_read_i),
        .char_read_i   (char_read_i),
        .b0c_i         (b0c_i),
        .b1c_i         (b1c_i),
        .b2c_i         (b2c_i),
        .b3c_i         (b3c_i),
        .ec_i          (ec_i),
        .border_i      (border_i),
        .sprite_pix_i  (sprite_pix_i),
        .sprite_pri_i  (sprite_pri_i),
        .sprite_mmc_i  (sprite_mmc_i),
        .sprite_col_i  (sprite_col_i),
        .sprite_mc0_i  (sprite_mc0_i),
        .sprite_mc1_i  (sprite_mc1_i),
        .pixel_color_o (pixel_color_o),
        .pixel_stb_o   (pixel_stb_o)
    );

    initial begin
        clk_dot4x = 1'b0;
        forever #20 clk_dot4x = ~clk_dot4x;
    end

    always @(posedge clk_dot4x) begin
        cycles++;
        if (cycle_limit > 0 && cycles >= cycle_limit) begin
            $display("run stopped, cycle limit of %0d reached", cycle_limit);
            $display("errors: %0d", errors + uut.u_chk.err_count + 1);
            $display("Testbench failed");
            $finish;
        end
    end

    // steps one 32-clock cell, optionally capturing pixel strobes
    task automatic step_cell(input bit collect);
        int i;
        for (i = 0; i < 32; i++) begin
            @(negedge clk_dot4x);
            if (collect && pixel_stb_o) begin
                got_q.push_back(pixel_color_o);
                got_t.push_back($time);
            end
            @(posedge clk_dot4x);
        end
        #2;
        cell_idx++;
    endtask

    task automatic load_stim_file();
        int    fd;
        string line;
        fd = $fopen("tests/video_pixel_stim.txt", "r");
        assert (fd != 0) else begin
            errors++;
            $display("stimulus file tests/video_pixel_stim.txt could not be opened");
        end
        if (fd != 0) begin
            while (!$feof(fd)) begin
                line = "";
                void'($fgets(line, fd));
                if (line.len() > 1 && line.getc(0) != 8'h23)
                    lines.push_back(line);
            end
            $fclose(fd);
        end
    endtask

    task automatic apply_record();
        xscroll_i     = fld[1][2:0];
        mode_i        = video_pkg::gfx_mode_e'(fld[0][2:0]);
        b0c_i         = fld[2][3:0];
        b1c_i         = fld[3][3:0];
        b2c_i         = fld[4][3:0];
        b3c_i         = fld[5][3:0];
        ec_i          = fld[6][3:0];
        border_i      = fld[7][0];
        pixels_read_i = fld[8][7:0];
        char_read_i   = fld[9][11:0];
        sprite_pix_i  = fld[10][15:0];
        sprite_pri_i  = fld[11][7:0];
        sprite_mmc_i  = fld[12][7:0];
        sprite_col_i  = fld[13];
        sprite_mc0_i  = fld[14][3:0];
        sprite_mc1_i  = fld[15][3:0];
    endtask

    task automatic compare_pixels(input int rec);
        video_pkg::color_t exp_c;
        int                k;
        assert (got_q.size() == 8) else begin
            errors++;
            $display("record %0d: expected 8 pixel_stb_o pulses in the check cell, saw %0d",
                     rec, got_q.size());
        end
        for (k = 0; k < 8 && k < got_q.size(); k++) begin
            exp_c = fld[16][31-4*k -: 4];
            assert (got_q[k] == exp_c) else begin
                errors++;
                $display("[ERROR] t=%0t pixel_color_o record %0d pixel %0d expected %h actual %h",
                         got_t[k], rec, k, exp_c, got_q[k]);
            end
        end
    endtask

    initial begin
        int r;
        int n;
        errors = 0;
        cycles = 0;
        cell_idx = 0;
        cycle_limit = 0;
        void'($urandom(32'h722c));
        rst = 1'b1;
        for (r = 0; r < 17; r++)
            fld[r] = 32'd0;
        apply_record();
        load_stim_file();
        // each record needs 4 cells; up to 23 idle cells per line to reach the scroll window
        cycle_limit = (16 + 4 * lines.size() + 23 * (lines.size() / 10 + 1)) * 32 + 210;
        repeat (10) @(posedge clk_dot4x);
        #2;
        rst = 1'b0;
        for (r = 0; r < lines.size(); r++) begin
            n = $sscanf(lines[r], "%h %h %h %h %h %h %h %h %h %h %h %h %h %h %h %h %h",
                        fld[0], fld[1], fld[2], fld[3], fld[4], fld[5], fld[6], fld[7],
                        fld[8], fld[9], fld[10], fld[11], fld[12], fld[13], fld[14],
                        fld[15], fld[16]);
            assert (n == 17) else begin
                errors++;
                $display("record %0d of the stimulus file has %0d fields instead of 17", r, n);
            end
            // record must start where its second and third cells latch the scroll
            while ((cell_idx % 63) < 14 || (cell_idx % 63) > 53) begin
                pixels_read_i = 8'($urandom);
                char_read_i   = 12'($urandom);
                step_cell(1'b0);
            end
            apply_record();
            step_cell(1'b0);
            step_cell(1'b0);
            step_cell(1'b0);
            // bus data fetched in the check cell never reaches its pixels
            pixels_read_i = 8'($urandom);
            char_read_i   = 12'($urandom);
            got_q.delete();
            got_t.delete();
            step_cell(1'b1);
            compare_pixels(r);
        end
        errors += uut.u_chk.err_count;
        $display("errors: %0d", errors);
        if (errors == 0)
            $display("Testbench passed");
        else
            $display("Testbench failed");
        $finish;
    end

endmodule

/* tests/video_pixel_stim.txt */
# mode scroll b0c b1c b2c b3c ec border pixels char spr_pix spr_pri spr_mmc spr_col mc0 mc1
# expected: eight 4-bit colours, first pixel in the leftmost digit
0 0 6 2 5 7 e 0 a5 341 0000 00 00 00000000 0 0 36366363
0 0 6 2 5 7 e 0 ff a00 0000 00 00 00000000 0 0 aaaaaaaa
0 0 6 2 5 7 e 0 00 123 0000 00 00 00000000 0 0 66666666
2 0 6 2 5 7 e 0 0f 0c4 0000 00 00 00000000 0 0 4444cccc
2 0 6 2 5 7 e 0 81 09b 0000 00 00 00000000 0 0 9bbbbbb9
1 0 6 2 5 7 e 0 1b 920 0000 00 00 00000000 0 0 66225511
1 0 6 2 5 7 e 0 e4 f00 0000 00 00 00000000 0 0 77552266
1 0 6 2 5 7 e 0 1b 512 0000 00 00 00000000 0 0 66655655
3 0 6 2 5 7 e 0 1b 348 0000 00 00 00000000 0 0 66448833
3 0 6 2 5 7 e 0 c6 348 0000 00 00 00000000 0 0 33664488
4 0 6 2 5 7 e 0 3c d40 0000 00 00 00000000 0 0 22dddd22
4 0 6 2 5 7 e 0 81 bc0 0000 00 00 00000000 0 0 b777777b
4 0 6 2 5 7 e 0 0f 880 0000 00 00 00000000 0 0 55558888
4 0 6 2 5 7 e 0 f0 305 0000 00 00 00000000 0 0 33336666
5 0 6 2 5 7 e 0 a5 341 0000 00 00 00000000 0 0 00000000
6 0 6 2 5 7 e 0 a5 341 0000 00 00 00000000 0 0 00000000
7 0 6 2 5 7 e 0 a5 341 0000 00 00 00000000 0 0 00000000
0 0 6 2 5 7 e 0 f0 a00 0200 00 00 000c0000 0 0 cccccccc
0 0 6 2 5 7 e 0 f0 a00 0200 08 00 000c0000 0 0 aaaacccc
0 0 6 2 5 7 e 0 f0 a00 2020 00 00 04000900 0 0 44444444
0 0 6 2 5 7 e 0 f0 a00 8800 01 00 40900000 0 0 aaaa4444
0 0 6 2 5 7 e 0 f0 a00 0880 04 00 00904000 0 0 aaaa9999
0 0 6 2 5 7 e 0 f0 a00 0004 00 40 00000000 b d bbbbbbbb
0 0 6 2 5 7 e 0 f0 a00 000c 00 40 00000000 b d dddddddd
0 0 6 2 5 7 e 0 f0 a00 0008 00 40 00000030 b d 33333333
0 0 6 2 5 7 e 1 a5 341 0200 00 00 000c0000 0 0 eeeeeeee
7 0 6 2 5 7 9 1 a5 341 0000 00 00 00000000 0 0 99999999
0 3 6 2 5 7 e 0 a5 341 0000 00 00 00000000 0 0 36336366
0 1 6 2 5 7 e 0 80 a00 0000 00 00 00000000 0 0 6a666666
3 5 6 2 5 7 e 0 1b 348 0000 00 00 00000000 0 0 48833664
0 7 6 2 5 7 e 0 01 a00 0000 00 00 00000000 0 0 666666a6

/* sim.f */
+incdir+src
src/video_pkg.sv
src/dot_timing.sv
src/gfx_delay_line.sv
src/pixel_sequencer.sv
src/pixel_compositor.sv
src/video_pixel_top.sv
tests/video_pixel_chk.sv
tests/tb_video_pixel.sv
